// File: source/udp_echo_cfg.svh
`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// Destination port that gets echoed back
`define UDP_ECHO_PORT 16'd1234

// Local address 192.168.1.128, most significant octet first
`define UDP_LOCAL_IP_O3 8'd192
`define UDP_LOCAL_IP_O2 8'd168
`define UDP_LOCAL_IP_O1 8'd1
`define UDP_LOCAL_IP_O0 8'd128

// TTL placed in every reply
`define UDP_REPLY_TTL 8'd64

// Payload FIFO depth is 2**UDP_FIFO_ADDR_WIDTH bytes
`define UDP_FIFO_ADDR_WIDTH 12

`endif

// File: source/udp_echo_pkg.sv
package udp_echo_pkg;

    // IPv4 address, whole word or octet by octet
    // octet[3] is the first octet in dotted notation
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] octet;
    } ip_addr_t;

    // Parsed UDP datagram header with the IP fields that matter here
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        ip_addr_t    ip_source_ip;
        ip_addr_t    ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
        // Always zero
        logic [47:0] reserved;
    } udp_hdr_t;

    // One payload byte with its stream markers
    typedef struct packed {
        logic [7:0] data;
        // Final byte of the datagram
        logic       last;
        // Error flag from the stack
        logic       user;
    } udp_byte_t;

endpackage

// File: source/udp_payload_fifo.sv
module udp_payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
)
(
    input  logic      clk_125mhz,
    input  logic      rst_125mhz,

    input  udp_byte_t wr_data,
    input  logic      wr_valid,
    output logic      wr_ready,

    output udp_byte_t rd_data,
    output logic      rd_valid,
    input  logic      rd_ready
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    udp_byte_t mem [0:DEPTH-1];

    // One extra bit to tell full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic ram_empty;
    logic full;
    logic wr_fire;
    logic out_load;
    logic bypass;
    logic ram_wr;
    logic ram_rd;

    assign ram_empty = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                       (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign wr_ready = ~full;
    assign wr_fire  = wr_valid & wr_ready;

    // Output register is free or being drained
    assign out_load = ~rd_valid | rd_ready;

    // With nothing stored, a new byte skips the RAM for one-cycle latency
    assign bypass = out_load & ram_empty & wr_fire;
    assign ram_wr = wr_fire & ~bypass;
    assign ram_rd = out_load & ~ram_empty;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (ram_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ram_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load) begin
                rd_valid <= ~ram_empty | wr_fire;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (ram_wr) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data;
        end
        if (ram_rd) begin
            rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end else if (bypass) begin
            rd_data <= wr_data;
        end
    end

endmodule

// File: source/udp_reply_hdr.sv
`include "udp_echo_cfg.svh"

module udp_reply_hdr
    import udp_echo_pkg::*;
(
    input  logic     clk_125mhz,
    input  logic     rst_125mhz,

    input  udp_hdr_t hdr_in,
    input  logic     in_valid,
    output logic     in_ready,

    output udp_hdr_t hdr_out,
    output logic     out_valid,
    input  logic     out_ready
);

    udp_hdr_t reply;
    ip_addr_t local_ip;

    always_comb begin
        local_ip.octet[3] = `UDP_LOCAL_IP_O3;
        local_ip.octet[2] = `UDP_LOCAL_IP_O2;
        local_ip.octet[1] = `UDP_LOCAL_IP_O1;
        local_ip.octet[0] = `UDP_LOCAL_IP_O0;

        reply                 = '0;
        reply.ip_ttl          = `UDP_REPLY_TTL;
        reply.ip_source_ip    = local_ip;
        // Send back to whoever sent it
        reply.ip_dest_ip.word = hdr_in.ip_source_ip.word;
        reply.source_port     = hdr_in.dest_port;
        reply.dest_port       = hdr_in.source_port;
        reply.length          = hdr_in.length;
    end

    // Empty, or the held header leaves this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (in_valid && in_ready) begin
            hdr_out <= reply;
        end
    end

endmodule

// File: source/udp_echo_ctrl.sv
`include "udp_echo_cfg.svh"

module udp_echo_ctrl
    import udp_echo_pkg::*;
(
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,

    input  logic [15:0] hdr_in_dest_port,
    input  logic        hdr_in_valid,
    output logic        hdr_in_ready,

    output logic        reply_valid,
    input  logic        reply_ready,

    input  udp_byte_t   payload_in,
    input  logic        payload_in_valid,
    output logic        payload_in_ready,

    output logic        fifo_wr_valid,
    input  logic        fifo_wr_ready,

    input  udp_byte_t   payload_out,
    input  logic        payload_out_valid,
    input  logic        payload_out_ready,

    output logic [7:0]  led
);

    logic match;
    logic ready_en;
    logic in_payload;
    logic match_reg;
    logic first_byte;
    logic hdr_fire;
    logic pay_fire;
    logic out_fire;

    assign match = (hdr_in_dest_port == `UDP_ECHO_PORT);

    // Headers are taken only between datagrams
    assign reply_valid  = hdr_in_valid & ready_en & ~in_payload & match;
    assign hdr_in_ready = ready_en & ~in_payload & (~match | reply_ready);
    assign hdr_fire     = hdr_in_valid & hdr_in_ready;

    // Matching payload goes to the FIFO, the rest is swallowed
    assign fifo_wr_valid    = payload_in_valid & in_payload & match_reg;
    assign payload_in_ready = in_payload & (~match_reg | fifo_wr_ready);
    assign pay_fire         = payload_in_valid & payload_in_ready;

    assign out_fire = payload_out_valid & payload_out_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            ready_en   <= 1'b0;
            in_payload <= 1'b0;
            match_reg  <= 1'b0;
        end else begin
            // Input handshakes open one cycle after reset is released
            ready_en <= 1'b1;
            if (hdr_fire) begin
                in_payload <= 1'b1;
                match_reg  <= match;
            end else if (pay_fire && payload_in.last) begin
                in_payload <= 1'b0;
            end
        end
    end

    // First byte of each outgoing datagram goes to the LEDs
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            first_byte <= 1'b1;
            led        <= 8'd0;
        end else if (out_fire) begin
            if (first_byte) begin
                led <= payload_out.data;
            end
            first_byte <= payload_out.last;
        end
    end

endmodule

// File: source/udp_echo_top.sv
`include "udp_echo_cfg.svh"

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,

    // Received datagrams from the UDP stack
    input  udp_hdr_t   hdr_in,
    input  logic       hdr_in_valid,
    output logic       hdr_in_ready,
    input  udp_byte_t  payload_in,
    input  logic       payload_in_valid,
    output logic       payload_in_ready,

    // Replies back to the UDP stack
    output udp_hdr_t   hdr_out,
    output logic       hdr_out_valid,
    input  logic       hdr_out_ready,
    output udp_byte_t  payload_out,
    output logic       payload_out_valid,
    input  logic       payload_out_ready,

    output logic [7:0] led
);

    logic reply_valid;
    logic reply_ready;
    logic fifo_wr_valid;
    logic fifo_wr_ready;

    udp_echo_ctrl udp_echo_ctrl_inst (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .hdr_in_dest_port  (hdr_in.dest_port),
        .hdr_in_valid      (hdr_in_valid),
        .hdr_in_ready      (hdr_in_ready),
        .reply_valid       (reply_valid),
        .reply_ready       (reply_ready),
        .payload_in        (payload_in),
        .payload_in_valid  (payload_in_valid),
        .payload_in_ready  (payload_in_ready),
        .fifo_wr_valid     (fifo_wr_valid),
        .fifo_wr_ready     (fifo_wr_ready),
        .payload_out       (payload_out),
        .payload_out_valid (payload_out_valid),
        .payload_out_ready (payload_out_ready),
        .led               (led)
    );

    udp_reply_hdr udp_reply_hdr_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .hdr_in     (hdr_in),
        .in_valid   (reply_valid),
        .in_ready   (reply_ready),
        .hdr_out    (hdr_out),
        .out_valid  (hdr_out_valid),
        .out_ready  (hdr_out_ready)
    );

    // Payload of matching datagrams only
    udp_payload_fifo #(
        .ADDR_WIDTH (`UDP_FIFO_ADDR_WIDTH)
    ) udp_payload_fifo_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_data    (payload_in),
        .wr_valid   (fifo_wr_valid),
        .wr_ready   (fifo_wr_ready),
        .rd_data    (payload_out),
        .rd_valid   (payload_out_valid),
        .rd_ready   (payload_out_ready)
    );

endmodule

// File: testbench/udp_echo_tb.sv
module udp_echo_tb
    import udp_echo_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_DGRAMS  = 40;
    localparam int          WAIT_LIMIT  = 1000;
    localparam int          DRAIN_LIMIT = 20000;
    localparam logic [15:0] ECHO_PORT   = 16'd1234;
    // 192.168.1.128
    localparam logic [31:0] LOCAL_IP    = 32'hc0a8_0180;
    localparam logic [7:0]  REPLY_TTL   = 8'd64;
    localparam logic [31:0] SEED        = 32'hb86f_b714;

    logic       clk_125mhz = 1'b0;
    logic       rst_125mhz = 1'b1;

    udp_hdr_t   hdr_in;
    logic       hdr_in_valid;
    logic       hdr_in_ready;
    udp_byte_t  payload_in;
    logic       payload_in_valid;
    logic       payload_in_ready;
    udp_hdr_t   hdr_out;
    logic       hdr_out_valid;
    logic       hdr_out_ready = 1'b0;
    udp_byte_t  payload_out;
    logic       payload_out_valid;
    logic       payload_out_ready = 1'b0;
    logic [7:0] led;

    // Expected replies in output order
    udp_hdr_t   exp_hdr_q[$];
    udp_byte_t  exp_byte_q[$];

    int unsigned cycle_count = 0;
    logic        rst_prev    = 1'b1;
    logic        hdr_stall   = 1'b0;
    udp_hdr_t    hdr_held;
    logic        pay_stall   = 1'b0;
    udp_byte_t   pay_held;
    logic        first_out   = 1'b1;
    logic [7:0]  led_exp     = 8'd0;

    udp_echo_top udp_echo_top_inst (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .hdr_in            (hdr_in),
        .hdr_in_valid      (hdr_in_valid),
        .hdr_in_ready      (hdr_in_ready),
        .payload_in        (payload_in),
        .payload_in_valid  (payload_in_valid),
        .payload_in_ready  (payload_in_ready),
        .hdr_out           (hdr_out),
        .hdr_out_valid     (hdr_out_valid),
        .hdr_out_ready     (hdr_out_ready),
        .payload_out       (payload_out),
        .payload_out_valid (payload_out_valid),
        .payload_out_ready (payload_out_ready),
        .led               (led)
    );

    always #4 clk_125mhz = ~clk_125mhz;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic timed_out(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        abort_run();
    endtask

    function automatic udp_hdr_t random_header(input bit to_echo, input int len);
        udp_hdr_t h;
        h                  = '0;
        h.ip_dscp          = 6'($urandom);
        h.ip_ecn           = 2'($urandom);
        h.ip_ttl           = 8'($urandom);
        h.ip_source_ip.word = $urandom;
        h.ip_dest_ip.word  = $urandom;
        h.source_port      = 16'($urandom);
        if (to_echo) begin
            h.dest_port = ECHO_PORT;
        end else begin
            h.dest_port = 16'($urandom);
            if (h.dest_port == ECHO_PORT) begin
                h.dest_port = h.dest_port + 16'd1;
            end
        end
        h.length   = 16'(len + 8);
        h.checksum = 16'($urandom);
        return h;
    endfunction

    // Reply as the echo rules describe it
    function automatic udp_hdr_t expected_reply(input udp_hdr_t rx);
        udp_hdr_t r;
        r                   = '0;
        r.ip_ttl            = REPLY_TTL;
        r.ip_source_ip.word = LOCAL_IP;
        r.ip_dest_ip        = rx.ip_source_ip;
        r.source_port       = rx.dest_port;
        r.dest_port         = rx.source_port;
        r.length            = rx.length;
        return r;
    endfunction

    task automatic send_header(input udp_hdr_t h);
        int waited;
        waited = 0;
        @(negedge clk_125mhz);
        hdr_in       = h;
        hdr_in_valid = 1'b1;
        @(posedge clk_125mhz);
        while (!hdr_in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out("hdr_in_ready");
            end
            @(posedge clk_125mhz);
        end
        @(negedge clk_125mhz);
        hdr_in_valid = 1'b0;
    endtask

    task automatic send_byte(input udp_byte_t b);
        int waited;
        waited = 0;
        @(negedge clk_125mhz);
        payload_in       = b;
        payload_in_valid = 1'b1;
        @(posedge clk_125mhz);
        while (!payload_in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out("payload_in_ready");
            end
            @(posedge clk_125mhz);
        end
    endtask

    task automatic pause_input(input int n);
        @(negedge clk_125mhz);
        payload_in_valid = 1'b0;
        repeat (n - 1) @(negedge clk_125mhz);
    endtask

    // Random back-pressure on both outputs
    always @(negedge clk_125mhz) begin
        hdr_out_ready     = ($urandom % 3) != 0;
        payload_out_ready = ($urandom % 4) != 0;
    end

    // Quiet outputs during reset and one cycle beyond
    always @(posedge clk_125mhz) begin
        if (cycle_count > 0 && (rst_125mhz || rst_prev)) begin
            assert (!hdr_out_valid && !payload_out_valid && !hdr_in_ready && !payload_in_ready)
            else report_mismatch("valid or ready high during or right after reset");
            assert (led == 8'd0)
            else report_mismatch($sformatf("led is %0h after reset", led));
        end
        rst_prev    <= rst_125mhz;
        cycle_count <= cycle_count + 1;
    end

    always @(posedge clk_125mhz) begin : check_hdr_out
        udp_hdr_t want;
        if (rst_125mhz) begin
            hdr_stall <= 1'b0;
        end else begin
            if (hdr_stall) begin
                assert (hdr_out_valid && hdr_out == hdr_held)
                else report_mismatch("hdr_out changed while stalled");
            end
            if (hdr_out_valid && hdr_out_ready) begin
                assert (exp_hdr_q.size() > 0)
                else report_mismatch("reply header with none expected");
                want = exp_hdr_q.pop_front();
                assert (hdr_out.source_port == want.source_port &&
                        hdr_out.dest_port == want.dest_port)
                else report_mismatch($sformatf("ports %0d/%0d, expected %0d/%0d",
                    hdr_out.source_port, hdr_out.dest_port,
                    want.source_port, want.dest_port));
                assert (hdr_out.ip_dest_ip.word == want.ip_dest_ip.word &&
                        hdr_out.ip_source_ip.word == want.ip_source_ip.word)
                else report_mismatch($sformatf("source IP %0d.%0d.%0d.%0d, dest IP %h",
                    hdr_out.ip_source_ip.octet[3], hdr_out.ip_source_ip.octet[2],
                    hdr_out.ip_source_ip.octet[1], hdr_out.ip_source_ip.octet[0],
                    hdr_out.ip_dest_ip.word));
                assert (hdr_out.ip_ttl == want.ip_ttl && hdr_out.ip_dscp == 6'd0 &&
                        hdr_out.ip_ecn == 2'd0 && hdr_out.checksum == 16'd0 &&
                        hdr_out.reserved == 48'd0)
                else report_mismatch("TTL, DSCP, ECN, checksum or reserved field wrong");
                assert (hdr_out.length == want.length)
                else report_mismatch($sformatf("length %0d, expected %0d",
                    hdr_out.length, want.length));
            end
            hdr_stall <= hdr_out_valid && !hdr_out_ready;
            hdr_held  <= hdr_out;
        end
    end

    always @(posedge clk_125mhz) begin : check_payload_out
        udp_byte_t want;
        if (rst_125mhz) begin
            pay_stall <= 1'b0;
            first_out <= 1'b1;
            led_exp   <= 8'd0;
        end else begin
            if (pay_stall) begin
                assert (payload_out_valid && payload_out == pay_held)
                else report_mismatch("payload_out changed while stalled");
            end
            assert (led == led_exp)
            else report_mismatch($sformatf("led %0h, expected %0h", led, led_exp));
            if (payload_out_valid && payload_out_ready) begin
                assert (exp_byte_q.size() > 0)
                else report_mismatch("payload byte with none expected");
                want = exp_byte_q.pop_front();
                assert (payload_out == want)
                else report_mismatch($sformatf("byte %h/%b/%b, expected %h/%b/%b",
                    payload_out.data, payload_out.last, payload_out.user,
                    want.data, want.last, want.user));
                if (first_out) begin
                    led_exp <= want.data;
                end
                first_out <= want.last;
            end
            pay_stall <= payload_out_valid && !payload_out_ready;
            pay_held  <= payload_out;
        end
    end

    initial begin
        udp_hdr_t  h;
        udp_byte_t b;
        int        len;
        int        waited;
        bit        echo;
        hdr_in           = '0;
        hdr_in_valid     = 1'b0;
        payload_in       = '0;
        payload_in_valid = 1'b0;
        void'($urandom(SEED));

        repeat (5) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        rst_125mhz = 1'b0;

        for (int n = 0; n < NUM_DGRAMS; n++) begin
            echo = ($urandom % 2) == 0;
            len  = 1 + int'($urandom % 64);
            h    = random_header(echo, len);
            if (echo) begin
                exp_hdr_q.push_back(expected_reply(h));
            end
            send_header(h);
            for (int i = 0; i < len; i++) begin
                b.data = 8'($urandom);
                b.last = (i == len - 1);
                b.user = b.last ? 1'($urandom) : 1'b0;
                if (echo) begin
                    exp_byte_q.push_back(b);
                end
                send_byte(b);
                if ($urandom % 4 == 0) begin
                    pause_input(1 + int'($urandom % 3));
                end
            end
            @(negedge clk_125mhz);
            payload_in_valid = 1'b0;
            repeat ($urandom % 5) @(negedge clk_125mhz);
        end

        // Let the outputs drain
        waited = 0;
        while (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) begin
            @(posedge clk_125mhz);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                timed_out("the expected replies to drain");
            end
        end
        repeat (4) @(posedge clk_125mhz);

        if (exp_hdr_q.size() == 0 && exp_byte_q.size() == 0 &&
            !hdr_out_valid && !payload_out_valid) begin
            $display("sim passed");
            $finish;
        end else begin
            report_mismatch("outputs still busy after all replies arrived");
        end
    end

endmodule

// File: tb.f
+incdir+source
source/udp_echo_pkg.sv
source/udp_payload_fifo.sv
source/udp_reply_hdr.sv
source/udp_echo_ctrl.sv
source/udp_echo_top.sv
testbench/udp_echo_tb.sv

// File: Makefile
# Verilator flow for the UDP echo responder

VERILATOR ?= verilator
TOP       ?= udp_echo_tb
RTL_TOP   ?= udp_echo_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= sim passed
FAIL_MSG  ?= sim failed

RTL_SRCS  ?= source/udp_echo_pkg.sv \
             source/udp_payload_fifo.sv \
             source/udp_reply_hdr.sv \
             source/udp_echo_ctrl.sv \
             source/udp_echo_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Isource $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
